/* filelist.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_mem_pkg.sv
logic/icache_store.sv
logic/icache_addr_unit.sv
logic/icache_hit_unit.sv
logic/icache_ctrl.sv
logic/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

/* logic/icache_addr_unit.sv */
/*
 * fetch address handling
 *   request address and bypass flag registers
 *   cacheable region decode with enable
 *   index, tag, offset and aligned refill address
 */

`include "icache_consts.svh"

module icache_addr_unit
  import icache_pkg::*;
  import icache_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       capture_i,     // request accepted this cycle
  input  ic_addr_t   fetch_addr_i,
  input  logic       en_i,          // cache enable
  output ic_index_t  idx_o,         // store address
  output ic_tag_t    req_tag_o,     // tag of the request in flight
  output ic_offset_t req_offset_o,
  output logic       bypass_o,      // registered bypass flag
  output logic       bypass_next_o, // bypass decision for the incoming address
  output mem_paddr_t mem_paddr_o,
  output logic       mem_nc_o
);

  ic_addr_t addr_q;   // request address, payload only
  ic_addr_t addr_cur; // incoming while capturing, registered otherwise
  logic     bypass_q;
  logic     in_region;

  // ********************
  // region decode
  // ********************
  assign in_region = (fetch_addr_i >= `IC_CACHEABLE_BASE) &&
                     (fetch_addr_i <= `IC_CACHEABLE_LIMIT);
  assign bypass_next_o = ~en_i | ~in_region; // disabled cache bypasses everything

  always_ff @(posedge clk_i) begin
    if (capture_i) addr_q <= fetch_addr_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bypass_q <= 1'b0;
    end else if (capture_i) begin
      bypass_q <= bypass_next_o;
    end
  end

  // speculative store read needs the new index in the accept cycle
  assign addr_cur     = capture_i ? fetch_addr_i : addr_q;
  assign idx_o        = addr_cur[IC_OFFSET_W +: IC_INDEX_W];
  assign req_tag_o    = addr_q[`IC_ADDR_W-1 -: IC_TAG_W];
  assign req_offset_o = addr_q[IC_OFFSET_W-1:0];
  assign bypass_o     = bypass_q;

  // ********************
  // refill address
  // ********************
  assign mem_nc_o    = capture_i ? bypass_next_o : bypass_q; // bypass request may start at accept
  assign mem_paddr_o = mem_nc_o ? {addr_cur[`IC_ADDR_W-1:2], 2'b00}                  // word
                                : {addr_cur[`IC_ADDR_W-1:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}}; // line

endmodule

/* logic/icache_consts.svh */
/*
 * instruction cache build constants
 *   address and fetch word widths
 *   line size in bytes and number of lines
 *   cacheable region bounds
 */

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// ********************
// widths
// ********************
`define IC_ADDR_W 32 // physical fetch address
`define IC_WORD_W 32 // one instruction word

// ********************
// geometry
// ********************
`define IC_LINE_BYTES 16 // four words per line
`define IC_NUM_LINES  64 // direct mapped, one line per index

// cacheable window, everything else goes straight to memory
`define IC_CACHEABLE_BASE  32'h8000_0000
`define IC_CACHEABLE_LIMIT 32'hFFFF_FFFF

`endif

/* logic/icache_ctrl.sv */
/*
 * cache controller FSM
 *   fetch accept with speculative store read
 *   tag compare, miss pulse, refill handshake
 *   return of the word and line allocation
 */

module icache_ctrl
  import icache_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_req_i,
  output logic fetch_ready_o,
  output logic fetch_valid_o,
  input  logic bypass_next_i,  // incoming fetch is non-cacheable
  input  logic bypass_i,       // fetch in flight is non-cacheable
  input  logic hit_i,
  output logic mem_req_o,
  input  logic mem_ack_i,
  input  logic mem_rtrn_vld_i,
  output logic capture_o,      // latch the fetch address
  output logic rd_en_o,        // read both stores
  output logic wr_en_o,        // write both stores and set valid
  output logic from_refill_o,  // word comes from the memory line
  output logic miss_o          // perf counter pulse
);

  ic_state_t state_q, state_d;
  logic      accept_en; // this cycle may take a new fetch

  // ********************
  // next state
  // ********************
  always_comb begin
    state_d       = state_q;
    accept_en     = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    capture_o     = 1'b0;
    rd_en_o       = 1'b0;
    wr_en_o       = 1'b0;
    from_refill_o = 1'b0;
    miss_o        = 1'b0;

    case (state_q)
      IDLE: begin
        accept_en = 1'b1;
      end

      TAG_COMPARE: begin
        if (hit_i) begin
          fetch_valid_o = 1'b1; // word from the data store
          accept_en     = 1'b1; // back to back hits
        end else begin
          miss_o    = 1'b1;
          mem_req_o = 1'b1;
          state_d   = mem_ack_i ? WAIT_MEM_DATA : WAIT_MEM_ACK;
        end
      end

      WAIT_MEM_ACK: begin
        mem_req_o = 1'b1; // hold until taken
        if (mem_ack_i) state_d = WAIT_MEM_DATA;
      end

      WAIT_MEM_DATA: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          from_refill_o = 1'b1;
          if (bypass_i) begin
            accept_en = 1'b1; // nothing to allocate
          end else begin
            wr_en_o = 1'b1;   // line is only on the port this cycle
            state_d = ALLOCATE;
          end
        end
      end

      ALLOCATE: begin
        state_d = IDLE; // store port was busy writing, resume next cycle
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // ********************
    // accept a new fetch
    // ********************
    if (accept_en) begin
      fetch_ready_o = 1'b1;
      state_d       = IDLE;
      if (fetch_req_i) begin
        capture_o = 1'b1;
        if (bypass_next_i) begin
          mem_req_o = 1'b1; // skip the tag check entirely
          state_d   = mem_ack_i ? WAIT_MEM_DATA : WAIT_MEM_ACK;
        end else begin
          rd_en_o = 1'b1;   // speculative tag and data read
          state_d = TAG_COMPARE;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* logic/icache_hit_unit.sv */
/*
 * hit detection and word select
 *   per line valid bits, cleared by reset
 *   tag compare against the request
 *   word pick from stored or refill line
 */

`include "icache_consts.svh"

module icache_hit_unit
  import icache_pkg::*;
  import icache_mem_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  ic_tag_entry_t tag_entry_i,   // tag store read data
  input  ic_tag_t       req_tag_i,
  input  ic_offset_t    req_offset_i,
  input  ic_line_t      store_line_i,  // data store read data
  input  mem_line_t     rtrn_line_i,   // line from memory
  input  logic          from_refill_i, // pick the returned line
  input  logic          alloc_i,       // line written this cycle
  input  ic_index_t     idx_i,
  output logic          hit_o,
  output ic_word_t      word_o
);

  localparam int BYTE_SEL_W = $clog2(`IC_WORD_W/8);   // byte bits inside a word
  localparam int WORD_SEL_W = IC_OFFSET_W - BYTE_SEL_W;

  logic [`IC_NUM_LINES-1:0] valid_q;  // one bit per line
  logic                     vld_rd_q; // read like the stores, one cycle behind
  logic [WORD_SEL_W-1:0]    wsel;
  ic_line_t                 line_sel;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q  <= '0; // invalidates the cache without a sweep
      vld_rd_q <= 1'b0;
    end else begin
      if (alloc_i) valid_q[idx_i] <= 1'b1;
      vld_rd_q <= valid_q[idx_i];
    end
  end

  assign hit_o = vld_rd_q & tag_entry_i.valid & (tag_entry_i.tag == req_tag_i);

  // ********************
  // word select
  // ********************
  assign wsel     = req_offset_i[IC_OFFSET_W-1:BYTE_SEL_W];
  assign line_sel = from_refill_i ? rtrn_line_i : store_line_i;
  assign word_o   = line_sel[wsel*`IC_WORD_W +: `IC_WORD_W];

endmodule

/* logic/icache_mem_pkg.sv */
/*
 * refill memory port types
 *   refill request address
 *   returned line
 */

`include "icache_consts.svh"

package icache_mem_pkg;

  // ********************
  // request side
  // ********************
  // word aligned when non-cacheable, line aligned otherwise
  typedef logic [`IC_ADDR_W-1:0] mem_paddr_t;

  // ********************
  // return side
  // ********************
  // always a full line, requested word sits at its own offset
  typedef logic [`IC_LINE_BYTES*8-1:0] mem_line_t;

endpackage

/* logic/icache_pkg.sv */
/*
 * fetch side and cache internal types
 *   derived field widths of a fetch address
 *   address, tag, index, offset, word and line types
 *   tag store entry and controller states
 */

`include "icache_consts.svh"

package icache_pkg;

  localparam int IC_OFFSET_W = $clog2(`IC_LINE_BYTES); // byte within line
  localparam int IC_INDEX_W  = $clog2(`IC_NUM_LINES);  // line select
  localparam int IC_TAG_W    = `IC_ADDR_W - IC_INDEX_W - IC_OFFSET_W;

  typedef logic [`IC_ADDR_W-1:0]       ic_addr_t;
  typedef logic [IC_INDEX_W-1:0]       ic_index_t;
  typedef logic [IC_OFFSET_W-1:0]      ic_offset_t;
  typedef logic [IC_TAG_W-1:0]         ic_tag_t;
  typedef logic [`IC_WORD_W-1:0]       ic_word_t;
  typedef logic [`IC_LINE_BYTES*8-1:0] ic_line_t;

  // one tag store word, valid on top
  typedef struct packed {
    logic    valid;
    ic_tag_t tag;
  } ic_tag_entry_t;

  typedef enum logic [2:0] {
    IDLE,          // accept a fetch
    TAG_COMPARE,   // stores read, check the tag
    WAIT_MEM_ACK,  // refill request held until ack
    WAIT_MEM_DATA, // waiting for the line to come back
    ALLOCATE       // turnaround after a line write
  } ic_state_t;

endpackage

/* logic/icache_store.sv */
/*
 * single port synchronous RAM
 *   entry type given as a parameter
 *   one cycle read latency, whole-entry writes
 */

`include "icache_consts.svh"

module icache_store
  import icache_pkg::*;
#(
  parameter type entry_t = logic,           // tag entry or full line
  parameter int  DEPTH   = `IC_NUM_LINES
) (
  input  logic      clk_i,
  input  logic      en_i,    // port enable
  input  logic      we_i,    // write when enabled, read otherwise
  input  ic_index_t addr_i,
  input  entry_t    wdata_i,
  output entry_t    rdata_o
);

  entry_t mem_q [DEPTH]; // storage array, contents undefined after reset
  entry_t rdata_q;       // read port register

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i; // whole entry, no byte enables
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  // read data holds until the next enabled read
  assign rdata_o = rdata_q;

endmodule

/* logic/icache_top.sv */
/*
 * direct mapped instruction cache top
 *   controller, address unit, hit unit
 *   tag store and data store
 */

module icache_top
  import icache_pkg::*;
  import icache_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,            // cache enable, low forces bypass
  // fetch port
  input  logic       fetch_req_i,
  input  ic_addr_t   fetch_addr_i,
  output logic       fetch_ready_o,
  output logic       fetch_valid_o,
  output ic_word_t   fetch_data_o,
  output logic       miss_o,          // to performance counter
  // refill port
  output logic       mem_req_o,
  input  logic       mem_ack_i,
  output mem_paddr_t mem_paddr_o,
  output logic       mem_nc_o,
  input  logic       mem_rtrn_vld_i,
  input  mem_line_t  mem_rtrn_line_i
);

  logic          capture, rd_en, wr_en, from_refill;
  logic          bypass, bypass_next, hit;
  ic_index_t     idx;
  ic_tag_t       req_tag;
  ic_offset_t    req_offset;
  ic_tag_entry_t tag_rdata;
  ic_line_t      line_rdata;

  // ********************
  // control
  // ********************
  icache_ctrl i_ctrl (
    .clk_i, .rst_ni, .fetch_req_i, .fetch_ready_o, .fetch_valid_o,
    .bypass_next_i (bypass_next), .bypass_i (bypass), .hit_i (hit),
    .mem_req_o, .mem_ack_i, .mem_rtrn_vld_i,
    .capture_o (capture), .rd_en_o (rd_en), .wr_en_o (wr_en),
    .from_refill_o (from_refill), .miss_o
  );

  icache_addr_unit i_addr_unit (
    .clk_i, .rst_ni, .capture_i (capture), .fetch_addr_i, .en_i,
    .idx_o (idx), .req_tag_o (req_tag), .req_offset_o (req_offset),
    .bypass_o (bypass), .bypass_next_o (bypass_next), .mem_paddr_o, .mem_nc_o
  );

  icache_hit_unit i_hit_unit (
    .clk_i, .rst_ni, .tag_entry_i (tag_rdata), .req_tag_i (req_tag),
    .req_offset_i (req_offset), .store_line_i (line_rdata), .rtrn_line_i (mem_rtrn_line_i),
    .from_refill_i (from_refill), .alloc_i (wr_en), .idx_i (idx),
    .hit_o (hit), .word_o (fetch_data_o)
  );

  // ********************
  // stores
  // ********************
  icache_store #(.entry_t (ic_tag_entry_t)) i_tag_store (
    .clk_i, .en_i (rd_en | wr_en), .we_i (wr_en), .addr_i (idx),
    .wdata_i (ic_tag_entry_t'{valid: 1'b1, tag: req_tag}), // tag of the refilled fetch
    .rdata_o (tag_rdata)
  );

  icache_store #(.entry_t (ic_line_t)) i_data_store (
    .clk_i, .en_i (rd_en | wr_en), .we_i (wr_en), .addr_i (idx),
    .wdata_i (mem_rtrn_line_i), // whole line straight from memory
    .rdata_o (line_rdata)
  );

endmodule

/* run.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module icache_tb -f filelist.f -o icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
exit 0

/* sim/icache_mem_model.sv */
/*
 * behavioral refill memory
 *   ack offered after 0 to 3 idle cycles, held until taken
 *   line returned 1 to 5 cycles after the handshake
 *   every word is its own address xor a fixed pattern
 */

`include "icache_consts.svh"

module icache_mem_model
  import icache_mem_pkg::*;
#(
  parameter logic [31:0] PATTERN = 32'hA5A5_0000 // xored into each word address
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       mem_req_i,
  input  mem_paddr_t mem_paddr_i,
  output logic       mem_ack_o,
  output logic       mem_rtrn_vld_o,
  output mem_line_t  mem_rtrn_line_o
);

  logic        ack_q   = 1'b0;
  logic        vld_q   = 1'b0;
  mem_line_t   line_q  = '0;
  logic        taken_q = 1'b0; // handshake at the last rising edge
  logic        busy    = 1'b0; // a line is still owed to the cache
  mem_paddr_t  paddr_q;
  int unsigned ack_wait;       // idle cycles left before ack
  int unsigned rtrn_wait;      // cycles left before the line goes out

  // whole line around paddr, so the requested word sits at its offset
  function automatic mem_line_t line_at(input mem_paddr_t paddr);
    mem_line_t  line;
    mem_paddr_t base;
    base = paddr & ~mem_paddr_t'(`IC_LINE_BYTES - 1);
    for (int w = 0; w < `IC_LINE_BYTES / 4; w++) begin
      line[w*32 +: 32] = (base + 32'(w * 4)) ^ PATTERN;
    end
    return line;
  endfunction

  always @(posedge clk_i) begin
    taken_q <= rst_ni & mem_req_i & ack_q; // same view of the handshake as the DUT
    if (mem_req_i & ack_q) paddr_q <= mem_paddr_i;
  end

  // ********************
  // outputs move on the falling edge only
  // ********************
  always @(negedge clk_i) begin
    vld_q <= 1'b0; // return is a one cycle pulse
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      busy     = 1'b0;
      ack_wait = $urandom_range(3, 0);
    end else if (taken_q) begin
      ack_q     <= 1'b0;
      busy      = 1'b1;
      rtrn_wait = $urandom_range(5, 1);
    end else if (busy) begin
      rtrn_wait--;
      if (rtrn_wait == 0) begin
        vld_q    <= 1'b1;
        line_q   <= line_at(paddr_q);
        busy     = 1'b0;
        ack_wait = $urandom_range(3, 0); // next ack only after the return
      end
    end else if (!ack_q) begin
      if (ack_wait == 0) ack_q <= 1'b1; // may already be up when a request rises
      else ack_wait--;
    end
  end

  assign mem_ack_o       = ack_q;
  assign mem_rtrn_vld_o  = vld_q;
  assign mem_rtrn_line_o = line_q;

endmodule

/* sim/icache_tb.sv */
/*
 * icache testbench
 *   directed then random fetch stimulus on the falling edge
 *   reference function for words, bypass and misses
 *   compare process on every returned word
 *   error count and cycle timeout
 */

`include "icache_consts.svh"

module icache_tb
  import icache_pkg::*;
  import icache_mem_pkg::*;
();

  localparam int NUM_RANDOM = 300;
  localparam int MAX_CYCLES = 40 * (NUM_RANDOM + 9) + 200; // 9 directed fetches

  logic       clk, rst_n, en, fetch_req, fetch_ready, fetch_valid, miss;
  logic       mem_req, mem_ack, mem_nc, mem_rtrn_vld;
  ic_addr_t   fetch_addr;
  ic_word_t   fetch_data;
  mem_paddr_t mem_paddr;
  mem_line_t  mem_rtrn_line;

  bit         ref_valid [`IC_NUM_LINES]; // tag model starts empty like the cache
  ic_tag_t    ref_tag [`IC_NUM_LINES];
  bit         pending;                   // accepted and not yet returned
  logic       exp_byp, exp_miss;
  ic_word_t   exp_word;
  mem_paddr_t exp_paddr;
  int         cycle_cnt, acc_cycle, acc_cnt, ret_cnt, miss_cnt, mem_cnt, err_cnt;

  always #4 clk = ~clk; // period 8

  icache_top i_icache_top (
    .clk_i (clk), .rst_ni (rst_n), .en_i (en),
    .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr), .fetch_ready_o (fetch_ready),
    .fetch_valid_o (fetch_valid), .fetch_data_o (fetch_data), .miss_o (miss),
    .mem_req_o (mem_req), .mem_ack_i (mem_ack), .mem_paddr_o (mem_paddr),
    .mem_nc_o (mem_nc), .mem_rtrn_vld_i (mem_rtrn_vld), .mem_rtrn_line_i (mem_rtrn_line)
  );

  icache_mem_model i_mem_model (
    .clk_i (clk), .rst_ni (rst_n), .mem_req_i (mem_req), .mem_paddr_i (mem_paddr),
    .mem_ack_o (mem_ack), .mem_rtrn_vld_o (mem_rtrn_vld), .mem_rtrn_line_o (mem_rtrn_line)
  );

  // ********************
  // reference
  // ********************
  function automatic ic_word_t mem_word(input ic_addr_t addr);
    return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  // bypass decision and miss prediction
  // a cacheable fetch always ends up allocated
  function automatic void predict(input ic_addr_t addr, input logic en_val,
                                  output logic byp, output logic missed);
    ic_index_t idx;
    ic_tag_t   tag;
    idx    = addr[9:4];   // 64 lines of 16 bytes
    tag    = addr[31:10];
    byp    = !en_val || addr < `IC_CACHEABLE_BASE || addr > `IC_CACHEABLE_LIMIT;
    missed = !byp && !(ref_valid[idx] && ref_tag[idx] == tag);
    if (!byp) begin
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
    end
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  // called on a falling edge and holds the request until the cache takes it
  task automatic fetch(input ic_addr_t addr, input logic en_val);
    fetch_req  = 1'b1;
    fetch_addr = addr;
    en         = en_val;
    @(posedge clk);
    while (!fetch_ready) @(posedge clk);
    @(negedge clk);
    fetch_req = 1'b0;
  endtask

  // ********************
  // compare process
  // ********************
  always @(posedge clk) begin
    cycle_cnt++;
    if (rst_n) begin
      // return of the fetch in flight comes before a new accept in the same cycle
      if (fetch_valid) begin
        if (!pending) begin
          $display("ERROR: fetch_valid_o came with no fetch pending");
          err_cnt++;
        end
        check("fetch_data_o", fetch_data, exp_word);
        check("miss_o pulses", miss_cnt, exp_miss);
        check("miss_o in the return cycle", miss, 0);
        check("mem_req_o handshakes", mem_cnt, exp_byp | exp_miss);
        if (!(exp_byp | exp_miss)) begin
          check("fetch_valid_o hit latency", cycle_cnt - acc_cycle, 1);
          if (!fetch_req) check("mem_req_o on a hit", mem_req, 0); // no new fetch to start
        end
        pending = 1'b0;
        ret_cnt++;
      end
      if (fetch_req && fetch_ready) begin
        if (pending) begin
          $display("ERROR: fetch accepted while the previous one was still in flight");
          err_cnt++;
        end
        predict(fetch_addr, en, exp_byp, exp_miss);
        exp_word  = mem_word(fetch_addr);
        exp_paddr = exp_byp ? {fetch_addr[31:2], 2'b00} : {fetch_addr[31:4], 4'h0};
        acc_cycle = cycle_cnt;
        miss_cnt  = 0;
        mem_cnt   = 0;
        pending   = 1'b1;
        acc_cnt++;
      end
      if (miss) miss_cnt++;
      if (mem_req && mem_ack) begin // belongs to the fetch accepted last
        mem_cnt++;
        check("mem_nc_o", mem_nc, exp_byp);
        check("mem_paddr_o", mem_paddr, exp_paddr);
      end
    end
  end

  // ********************
  // stimulus
  // ********************
  initial begin
    ic_addr_t addr;
    logic     en_val;
    void'($urandom(32'h194)); // one seed for the whole run
    clk        = 1'b0;
    rst_n      = 1'b0;
    en         = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("fetch_ready_o", fetch_ready, 1);
    check("fetch_valid_o", fetch_valid, 0);
    check("mem_req_o", mem_req, 0);
    check("miss_o", miss, 0);

    fetch(32'h8000_1230, 1'b1); // cold miss
    fetch(32'h8000_1230, 1'b1); // same word hits
    fetch(32'h8000_1238, 1'b1); // other word of the same line
    fetch(32'h8000_1630, 1'b1); // new tag on the same index evicts
    fetch(32'h8000_1230, 1'b1); // old line misses again
    fetch(32'h0000_2006, 1'b1); // below the cacheable base
    fetch(32'h0000_2006, 1'b1);
    fetch(32'h8000_123A, 1'b0); // cache disabled while the line is cached
    fetch(32'h8000_123A, 1'b0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      if ($urandom_range(7, 0) == 0) begin
        addr = $urandom & 32'h7FFF_FFFF; // non-cacheable
      end else begin
        // 4 tags over 8 indices so lines get evicted and hit again
        addr = `IC_CACHEABLE_BASE | ($urandom_range(3, 0) << 10)
             | ($urandom_range(7, 0) << 4) | ($urandom_range(3, 0) << 2);
      end
      en_val = $urandom_range(9, 0) != 0; // cache off one time in ten
      fetch(addr, en_val);
      if ($urandom_range(3, 0) == 0) @(negedge clk); // idle gap
    end

    while (pending) @(negedge clk);
    repeat (4) @(negedge clk); // room for a stray valid
    check("fetch_valid_o count", ret_cnt, acc_cnt);
    $display("errors: %0d  fetches accepted: %0d  returned: %0d", err_cnt, acc_cnt, ret_cnt);
    if (err_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // stops a run where the DUT never answers
  initial begin
    while (cycle_cnt < MAX_CYCLES) @(negedge clk);
    $display("ERROR: run timed out after %0d cycles with %0d errors", cycle_cnt, err_cnt);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
